/* src/ttc_lite_consts.svh */
// shared widths, register offsets and bit positions; include wherever the timer macros are used
`ifndef TTC_LITE_CONSTS_SVH
`define TTC_LITE_CONSTS_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------
`define TTC_CNT_WIDTH       16
`define TTC_ADDR_WIDTH      5
`define TTC_CLK_CTRL_WIDTH  7

// register offsets on the bus
`define TTC_ADDR_CLK_CTRL   5'h00
`define TTC_ADDR_CNTR_CTRL  5'h04
`define TTC_ADDR_INTERVAL   5'h08
`define TTC_ADDR_VALUE      5'h0C
`define TTC_ADDR_STATUS     5'h10

// counter control bits
`define TTC_CTRL_DISABLE    0
`define TTC_CTRL_INTERVAL   1
`define TTC_CTRL_RESTART    2

// clock control fields, bits 6:5 kept but unused
`define TTC_CLK_PS_EN       0
`define TTC_CLK_PS_LSB      1
`define TTC_CLK_PS_MSB      4

// sticky status bits
`define TTC_STAT_INTERVAL   0
`define TTC_STAT_OVERFLOW   1

`endif

/* src/ttc_lite_pkg.sv */
// shared count, address and prescale types; compile first and import where the types are needed
`include "ttc_lite_consts.svh"

package ttc_lite_pkg;

  // ------------------------------------------------------------
  // data types
  // ------------------------------------------------------------

  // count value and interval limit
  typedef logic [`TTC_CNT_WIDTH-1:0] ttc_count_t;

  // register offset on the peripheral bus
  typedef logic [`TTC_ADDR_WIDTH-1:0] ttc_addr_t;

  // prescale exponent from clock control bits 4:1
  // one tick per 2^(p+1) cycles
  typedef logic [`TTC_CLK_PS_MSB-`TTC_CLK_PS_LSB:0] ttc_ps_t;

  // ------------------------------------------------------------
  // notes
  // ------------------------------------------------------------

  // count and interval share one width so the
  // interval compare needs no extension

  // address type is wide enough for the five
  // word offsets 0x00 to 0x10

  // prescale field of 4 bits gives a divide
  // range of 2 up to 65536

endpackage

/* src/ttc_regs.sv */
// bus decode and register file of the timer channel; instantiated once inside ttc_timer_lite
`include "ttc_lite_consts.svh"

module ttc_regs
  import ttc_lite_pkg::*;
(
  input  logic                           pclk19,
  input  logic                           n_p_reset19,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  ttc_addr_t                      paddr,
  input  logic [31:0]                    pwdata,
  input  logic [`TTC_CLK_CTRL_WIDTH-1:0] clk_ctrl_reg_out,
  input  ttc_count_t                     value,
  input  logic                           interval_event,
  input  logic                           overflow_event,
  output logic [31:0]                    prdata,
  output logic                           clk_ctrl_reg_sel,
  output logic                           restart,
  output logic                           cntr_disable,
  output logic                           interval_mode,
  output ttc_count_t                     interval,
  output logic                           irq
);

  logic       wr_en;
  logic [2:0] cntr_ctrl;
  logic [1:0] status;
  logic [1:0] status_set;
  logic [1:0] status_clr;

  // ------------------------------------------------------------
  // write decode
  // ------------------------------------------------------------

  // access phase of a write
  assign wr_en = psel & penable & pwrite;

  // clock control lives in the counter reset block
  assign clk_ctrl_reg_sel = wr_en & (paddr == `TTC_ADDR_CLK_CTRL);

  // write-one-to-clear on the status offset
  assign status_clr = (wr_en && paddr == `TTC_ADDR_STATUS) ? pwdata[1:0] : 2'b00;

  // event pulses from the counter
  assign status_set[`TTC_STAT_INTERVAL] = interval_event;
  assign status_set[`TTC_STAT_OVERFLOW] = overflow_event;

  always_ff @(posedge pclk19 or negedge n_p_reset19)
  begin
    if (!n_p_reset19)
    begin
      cntr_ctrl <= 3'b000;
      interval  <= '0;
      status    <= 2'b00;
    end
    else
    begin
      if (wr_en && paddr == `TTC_ADDR_CNTR_CTRL)
        cntr_ctrl <= pwdata[2:0];
      if (wr_en && paddr == `TTC_ADDR_INTERVAL)
        interval <= pwdata[`TTC_CNT_WIDTH-1:0];
      // set beats clear in the same cycle
      status <= (status & ~status_clr) | status_set;
    end
  end

  assign cntr_disable  = cntr_ctrl[`TTC_CTRL_DISABLE];
  assign interval_mode = cntr_ctrl[`TTC_CTRL_INTERVAL];
  assign restart       = cntr_ctrl[`TTC_CTRL_RESTART];
  assign irq           = |status;

  // ------------------------------------------------------------
  // read mux
  // ------------------------------------------------------------

  always_comb
  begin
    prdata = 32'h0;
    if (psel && !pwrite)
    begin
      case (paddr)
        `TTC_ADDR_CLK_CTRL:  prdata = 32'(clk_ctrl_reg_out);
        `TTC_ADDR_CNTR_CTRL: prdata = 32'(cntr_ctrl);
        `TTC_ADDR_INTERVAL:  prdata = 32'(interval);
        `TTC_ADDR_VALUE:     prdata = 32'(value);
        `TTC_ADDR_STATUS:    prdata = 32'(status);
        // unmapped offsets read zero
        default:             prdata = 32'h0;
      endcase
    end
  end

  // select strobe only in an access phase that followed a setup phase
  a_sel_on_write: assert property (@(posedge pclk19) disable iff (!n_p_reset19)
    clk_ctrl_reg_sel |-> (wr_en && $past(psel && !penable)));

endmodule

/* src/ttc_count_rst_lite.sv */
// clock control register and restart-edge count enable; one instance per timer channel
`include "ttc_lite_consts.svh"

module ttc_count_rst_lite
(
  input  logic                           pclk19,
  input  logic                           n_p_reset19,
  input  logic [`TTC_CLK_CTRL_WIDTH-1:0] pwdata,
  input  logic                           clk_ctrl_reg_sel,
  input  logic                           restart,
  output logic                           count_en_out,
  output logic [`TTC_CLK_CTRL_WIDTH-1:0] clk_ctrl_reg_out
);

  logic [`TTC_CLK_CTRL_WIDTH-1:0] clk_ctrl_reg;
  // remembers restart was seen high
  logic                           restart_seen;
  logic                           count_en;

  // ------------------------------------------------------------
  // count enable
  // ------------------------------------------------------------

  // low for one cycle out of reset and on each restart rising edge
  always_ff @(posedge pclk19 or negedge n_p_reset19)
  begin
    if (!n_p_reset19)
    begin
      restart_seen <= 1'b0;
      count_en     <= 1'b0;
    end
    else if (restart && !restart_seen)
    begin
      restart_seen <= 1'b1;
      count_en     <= 1'b0;
    end
    else
    begin
      // rearm once restart drops
      if (!restart)
        restart_seen <= 1'b0;
      count_en <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // clock control register
  // ------------------------------------------------------------

  always_ff @(posedge pclk19 or negedge n_p_reset19)
  begin
    if (!n_p_reset19)
      clk_ctrl_reg <= '0;
    else if (clk_ctrl_reg_sel)
      clk_ctrl_reg <= pwdata;
  end

  assign clk_ctrl_reg_out = clk_ctrl_reg;
  assign count_en_out     = count_en;

  // a held restart never stretches the enable drop
  a_en_one_cycle_low: assert property (@(posedge pclk19) disable iff (!n_p_reset19)
    !count_en_out |=> count_en_out);

endmodule

/* src/ttc_prescaler.sv */
// count tick generator selected by clock control; sits between the counter reset block and counter
`include "ttc_lite_consts.svh"

module ttc_prescaler
  import ttc_lite_pkg::*;
(
  input  logic                           pclk19,
  input  logic                           n_p_reset19,
  input  logic                           count_en,
  input  logic [`TTC_CLK_CTRL_WIDTH-1:0] clk_ctrl_reg_out,
  output logic                           tick
);

  logic        ps_en;
  ttc_ps_t     ps_exp;
  // free divider one bit wider than the largest field
  logic [16:0] div_cnt;
  logic [16:0] div_mask;
  logic        div_roll;

  // ------------------------------------------------------------
  // field decode
  // ------------------------------------------------------------

  assign ps_en  = clk_ctrl_reg_out[`TTC_CLK_PS_EN];
  assign ps_exp = clk_ctrl_reg_out[`TTC_CLK_PS_MSB:`TTC_CLK_PS_LSB];

  // low p+1 bits set to give 2^(p+1)-1
  assign div_mask = (17'd2 << ps_exp) - 17'd1;

  // ------------------------------------------------------------
  // divider
  // ------------------------------------------------------------

  // held at zero while disabled so the phase restarts cleanly
  always_ff @(posedge pclk19 or negedge n_p_reset19)
  begin
    if (!n_p_reset19)
      div_cnt <= '0;
    else if (!count_en)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 17'd1;
  end

  // low bits about to roll over
  assign div_roll = ((div_cnt & div_mask) == div_mask);

  // bypass gives a tick every enabled cycle
  assign tick = count_en & (!ps_en | div_roll);

  // a prescaled tick needs a divider that already ran in the cycle before
  a_tick_after_enable: assert property (@(posedge pclk19) disable iff (!n_p_reset19)
    (ps_en && tick) |-> $past(count_en));

endmodule

/* src/ttc_counter.sv */
// 16-bit channel counter with interval and overflow wrap; driven by the prescaler tick
`include "ttc_lite_consts.svh"

module ttc_counter
  import ttc_lite_pkg::*;
(
  input  logic       pclk19,
  input  logic       n_p_reset19,
  input  logic       count_en,
  input  logic       tick,
  input  logic       cntr_disable,
  input  logic       interval_mode,
  input  ttc_count_t interval,
  output ttc_count_t value,
  output logic       interval_event,
  output logic       overflow_event
);

  logic step;
  logic hit_interval;
  logic hit_max;

  // ------------------------------------------------------------
  // wrap conditions
  // ------------------------------------------------------------

  // a tick counts only while not disabled
  assign step = tick & ~cntr_disable;

  // interval compare only in interval mode
  assign hit_interval = interval_mode & (value == interval);
  assign hit_max      = (value == '1);

  // ------------------------------------------------------------
  // count and event pulses
  // ------------------------------------------------------------

  // events line up with the wrapped value
  always_ff @(posedge pclk19 or negedge n_p_reset19)
  begin
    if (!n_p_reset19)
    begin
      value          <= '0;
      interval_event <= 1'b0;
      overflow_event <= 1'b0;
    end
    else if (!count_en)
    begin
      // restart clears the count
      value          <= '0;
      interval_event <= 1'b0;
      overflow_event <= 1'b0;
    end
    else
    begin
      interval_event <= 1'b0;
      overflow_event <= 1'b0;
      if (step)
      begin
        if (hit_interval)
        begin
          value          <= '0;
          interval_event <= 1'b1;
        end
        else if (hit_max)
        begin
          value          <= '0;
          overflow_event <= 1'b1;
        end
        else
        begin
          value <= value + 1'b1;
        end
      end
    end
  end

  // an all-ones interval in interval mode wraps as an interval event and never as overflow
  a_interval_first: assert property (@(posedge pclk19) disable iff (!n_p_reset19)
    overflow_event |-> !$past(interval_mode && interval == '1));

endmodule

/* src/ttc_timer_lite.sv */
// top level of the single-channel timer; the DUT seen by the bus testbench
`include "ttc_lite_consts.svh"

module ttc_timer_lite
  import ttc_lite_pkg::*;
(
  input  logic        pclk19,
  input  logic        n_p_reset19,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  ttc_addr_t   paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        irq
);

  // ------------------------------------------------------------
  // internal wiring
  // ------------------------------------------------------------

  logic                           clk_ctrl_reg_sel;
  logic                           restart;
  logic                           cntr_disable;
  logic                           interval_mode;
  ttc_count_t                     interval;
  logic [`TTC_CLK_CTRL_WIDTH-1:0] clk_ctrl_reg_out;
  logic                           count_en;
  logic                           tick;
  ttc_count_t                     value;
  logic                           interval_event;
  logic                           overflow_event;

  // bus decode and registers
  ttc_regs i_regs (
    .pclk19           (pclk19),
    .n_p_reset19      (n_p_reset19),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .clk_ctrl_reg_out (clk_ctrl_reg_out),
    .value            (value),
    .interval_event   (interval_event),
    .overflow_event   (overflow_event),
    .prdata           (prdata),
    .clk_ctrl_reg_sel (clk_ctrl_reg_sel),
    .restart          (restart),
    .cntr_disable     (cntr_disable),
    .interval_mode    (interval_mode),
    .interval         (interval),
    .irq              (irq)
  );

  // clock control and count enable
  ttc_count_rst_lite i_count_rst (
    .pclk19           (pclk19),
    .n_p_reset19      (n_p_reset19),
    .pwdata           (pwdata[`TTC_CLK_CTRL_WIDTH-1:0]),
    .clk_ctrl_reg_sel (clk_ctrl_reg_sel),
    .restart          (restart),
    .count_en_out     (count_en),
    .clk_ctrl_reg_out (clk_ctrl_reg_out)
  );

  ttc_prescaler i_prescaler (
    .pclk19           (pclk19),
    .n_p_reset19      (n_p_reset19),
    .count_en         (count_en),
    .clk_ctrl_reg_out (clk_ctrl_reg_out),
    .tick             (tick)
  );

  ttc_counter i_counter (
    .pclk19         (pclk19),
    .n_p_reset19    (n_p_reset19),
    .count_en       (count_en),
    .tick           (tick),
    .cntr_disable   (cntr_disable),
    .interval_mode  (interval_mode),
    .interval       (interval),
    .value          (value),
    .interval_event (interval_event),
    .overflow_event (overflow_event)
  );

endmodule

/* sim/ttc_checker.sv */
// cycle model of the timer channel; instantiated by the testbench to compare prdata and irq
`include "ttc_lite_consts.svh"

module ttc_checker
  import ttc_lite_pkg::*;
(
  input logic        pclk19,
  input logic        n_p_reset19,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input ttc_addr_t   paddr,
  input logic [31:0] pwdata,
  input logic [31:0] prdata,
  input logic        irq
);

  // model state
  logic [`TTC_CLK_CTRL_WIDTH-1:0] m_clk_ctrl;
  logic [2:0]                     m_ctrl;
  ttc_count_t                     m_interval;
  ttc_count_t                     m_value;
  logic [1:0]                     m_status;
  logic                           m_en;
  logic                           m_restart_q;
  logic                           m_int_ev;
  logic                           m_ovf_ev;
  logic                           m_tick;
  ttc_ps_t                        m_ps;
  int unsigned                    m_phase;
  logic                           wr;
  int                             errors = 0;

  // expected read data from the model registers
  function automatic logic [31:0] model_read(input ttc_addr_t addr);
    case (addr)
      `TTC_ADDR_CLK_CTRL:  return 32'(m_clk_ctrl);
      `TTC_ADDR_CNTR_CTRL: return 32'(m_ctrl);
      `TTC_ADDR_INTERVAL:  return 32'(m_interval);
      `TTC_ADDR_VALUE:     return 32'(m_value);
      `TTC_ADDR_STATUS:    return 32'(m_status);
      default:             return 32'h0;
    endcase
  endfunction

  // ------------------------------------------------------------
  // compare, then step the model by one cycle
  // ------------------------------------------------------------
  always @(posedge pclk19 or negedge n_p_reset19)
  begin
    if (!n_p_reset19)
    begin
      m_clk_ctrl  = '0;
      m_ctrl      = '0;
      m_interval  = '0;
      m_value     = '0;
      m_status    = '0;
      m_en        = 1'b0;
      m_restart_q = 1'b0;
      m_int_ev    = 1'b0;
      m_ovf_ev    = 1'b0;
      m_phase     = 0;
    end
    else
    begin
      if (psel && penable && !pwrite && prdata !== model_read(paddr))
      begin
        $display("MISMATCH prdata at paddr %h: got %h expected %h",
                 paddr, prdata, model_read(paddr));
        errors++;
      end
      if (irq !== (m_status != 2'b00))
      begin
        $display("MISMATCH irq: got %h expected %h", irq, (m_status != 2'b00));
        errors++;
      end
      wr = psel && penable && pwrite;
      // one tick per 2^(p+1) enabled cycles, or every cycle when bypassed
      m_ps   = m_clk_ctrl[`TTC_CLK_PS_MSB:`TTC_CLK_PS_LSB];
      m_tick = m_en && (!m_clk_ctrl[`TTC_CLK_PS_EN] || ((m_phase + 1) % (2 << m_ps)) == 0);
      // sticky status, set wins over clear
      if (wr && paddr == `TTC_ADDR_STATUS)
        m_status = m_status & ~pwdata[1:0];
      m_status = m_status | {m_ovf_ev, m_int_ev};
      m_int_ev = 1'b0;
      m_ovf_ev = 1'b0;
      if (!m_en)
        m_value = '0;
      else if (m_tick && !m_ctrl[`TTC_CTRL_DISABLE])
      begin
        if (m_ctrl[`TTC_CTRL_INTERVAL] && m_value == m_interval)
        begin
          m_value  = '0;
          m_int_ev = 1'b1;
        end
        else if (m_value == 16'hffff)
        begin
          m_value  = '0;
          m_ovf_ev = 1'b1;
        end
        else
          m_value = m_value + 1'b1;
      end
      m_phase = m_en ? m_phase + 1 : 0;
      // enable drops for one cycle on the restart rising edge
      m_en        = !(m_ctrl[`TTC_CTRL_RESTART] && !m_restart_q);
      m_restart_q = m_ctrl[`TTC_CTRL_RESTART];
      if (wr && paddr == `TTC_ADDR_CLK_CTRL)
        m_clk_ctrl = pwdata[`TTC_CLK_CTRL_WIDTH-1:0];
      if (wr && paddr == `TTC_ADDR_CNTR_CTRL)
        m_ctrl = pwdata[2:0];
      if (wr && paddr == `TTC_ADDR_INTERVAL)
        m_interval = pwdata[`TTC_CNT_WIDTH-1:0];
    end
  end

endmodule

/* sim/tb_ttc_lite.sv */
// bus testbench of the timer channel; runs six seeded random tests against ttc_timer_lite
`include "ttc_lite_consts.svh"

module tb_ttc_lite
  import ttc_lite_pkg::*;
();

  // per-test cycle budgets
  localparam int T_REGS = 400;
  localparam int T_PRESCALE = 2400;
  localparam int T_RESTART = 600;
  localparam int T_INTERVAL = 1500;
  localparam int T_OVERFLOW = 66200;
  localparam int T_DISABLE = 1200;
  localparam int CYCLE_LIMIT =
    2 * (T_REGS + T_PRESCALE + T_RESTART + T_INTERVAL + T_OVERFLOW + T_DISABLE);

  logic        pclk19;
  logic        n_p_reset19;
  logic        psel;
  logic        penable;
  logic        pwrite;
  ttc_addr_t   paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        irq;
  int          tb_errors = 0;
  int          last_total = 0;
  int          tests_run = 0;
  int          cycles = 0;
  logic [31:0] rd;
  logic [31:0] held;
  ttc_count_t  lim;

  ttc_timer_lite i_dut (
    .pclk19      (pclk19),
    .n_p_reset19 (n_p_reset19),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .irq         (irq)
  );

  ttc_checker i_chk (
    .pclk19      (pclk19),
    .n_p_reset19 (n_p_reset19),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .irq         (irq)
  );

  always #5 pclk19 = ~pclk19;

  // run limit
  always @(posedge pclk19)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // bus tasks entered and left on a falling edge
  // ------------------------------------------------------------
  task automatic bus_write(input ttc_addr_t addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge pclk19);
    penable = 1'b1;
    @(negedge pclk19);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic bus_read(input ttc_addr_t addr, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge pclk19);
    penable = 1'b1;
    // access phase sample
    @(posedge pclk19);
    data = prdata;
    @(negedge pclk19);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge pclk19);
  endtask

  task automatic wait_irq();
    while (!irq)
      @(negedge pclk19);
  endtask

  task automatic report_test(input string name);
    int total;
    total = i_chk.errors + tb_errors;
    $display("%s: %0d errors", name, total - last_total);
    last_total = total;
    tests_run++;
  endtask

  initial
  begin
    pclk19      = 1'b0;
    n_p_reset19 = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    void'($urandom(32'h1cefb55a));
    repeat (8) @(negedge pclk19);
    n_p_reset19 = 1'b1;
    wait_cycles(2);

    // 1. register readback and unmapped offsets
    repeat (4)
    begin
      bus_write(`TTC_ADDR_CLK_CTRL, $urandom);
      bus_read(`TTC_ADDR_CLK_CTRL, rd);
      bus_write(`TTC_ADDR_CNTR_CTRL, $urandom & ~32'h4);
      bus_read(`TTC_ADDR_CNTR_CTRL, rd);
      bus_write(`TTC_ADDR_INTERVAL, $urandom);
      bus_read(`TTC_ADDR_INTERVAL, rd);
      bus_read(`TTC_ADDR_VALUE, rd);
    end
    for (int k = 5; k < 8; k++)
      bus_read(ttc_addr_t'(k * 4), rd);
    bus_read(5'h02, rd);
    report_test("register readback");

    // 2. prescaler rate with the last round bypassed
    for (int i = 0; i < 6; i++)
    begin
      bus_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
      bus_write(`TTC_ADDR_CLK_CTRL, {2'($urandom), 4'($urandom), (i != 5)});
      bus_write(`TTC_ADDR_CNTR_CTRL, 32'h4);
      wait_cycles($urandom_range(10, 300));
      bus_read(`TTC_ADDR_VALUE, rd);
    end
    report_test("prescaler rate");

    // 3. restart edge, held level, second edge
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
    bus_write(`TTC_ADDR_CLK_CTRL, 32'h3);
    wait_cycles($urandom_range(5, 40));
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h4);
    bus_read(`TTC_ADDR_VALUE, rd);
    wait_cycles($urandom_range(20, 100));
    bus_read(`TTC_ADDR_VALUE, rd);
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
    wait_cycles($urandom_range(5, 40));
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h4);
    bus_read(`TTC_ADDR_VALUE, rd);
    report_test("restart");

    // 4. interval mode and status bit 0
    lim = ttc_count_t'($urandom_range(3, 40));
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
    bus_write(`TTC_ADDR_CLK_CTRL, 32'h0);
    bus_write(`TTC_ADDR_INTERVAL, 32'(lim));
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h6);
    wait_cycles(3);
    repeat (8)
    begin
      wait_cycles($urandom_range(1, 30));
      bus_read(`TTC_ADDR_VALUE, rd);
      if (rd > 32'(lim))
      begin
        $display("MISMATCH value: got %h above interval %h", rd, lim);
        tb_errors++;
      end
    end
    wait_irq();
    bus_read(`TTC_ADDR_STATUS, rd);
    bus_write(`TTC_ADDR_STATUS, 32'h1);
    bus_read(`TTC_ADDR_STATUS, rd);
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
    report_test("interval mode");

    // 5. overflow wrap from a restart
    bus_write(`TTC_ADDR_STATUS, 32'h3);
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h4);
    wait_irq();
    bus_read(`TTC_ADDR_STATUS, rd);
    bus_read(`TTC_ADDR_VALUE, rd);
    bus_write(`TTC_ADDR_STATUS, 32'h2);
    bus_read(`TTC_ADDR_STATUS, rd);
    report_test("overflow");

    // 6. disable holds the count
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h1);
    bus_read(`TTC_ADDR_VALUE, held);
    repeat (4)
    begin
      wait_cycles($urandom_range(10, 200));
      bus_read(`TTC_ADDR_VALUE, rd);
      if (rd !== held)
      begin
        $display("MISMATCH value: got %h held %h", rd, held);
        tb_errors++;
      end
    end
    bus_write(`TTC_ADDR_CNTR_CTRL, 32'h0);
    wait_cycles($urandom_range(5, 50));
    bus_read(`TTC_ADDR_VALUE, rd);
    report_test("disable");

    $display("totals: %0d tests, %0d errors", tests_run, last_total);
    if (last_total == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* build.f */
+incdir+src
src/ttc_lite_pkg.sv
src/ttc_regs.sv
src/ttc_count_rst_lite.sv
src/ttc_prescaler.sv
src/ttc_counter.sv
src/ttc_timer_lite.sv
sim/ttc_checker.sv
sim/tb_ttc_lite.sv
